//--- build.f
+incdir+verilog
verilog/trit_dma_pkg.sv
verilog/host_regs.sv
verilog/read_master.sv
verilog/write_master.sv
verilog/trit_sequencer.sv
verilog/trit_dma_top.sv
verif/trit_dma_properties.sv
verif/tb_trit_dma.sv

//--- verif/tb_trit_dma.sv
// testbench for the trit transfer engine with a stalling memory model and host register tasks
`timescale 1ns/1ps
`default_nettype none
`include "trit_dma_consts.svh"

module tb_trit_dma;

    localparam int MEM_WORDS  = 64;
    localparam int NUM_RUNS   = 3;
    localparam int RUN_CYCLES = 2000;

    logic                       i_clk;
    logic                       i_arst;
    logic                       i_slave_write;
    logic                       i_slave_read;
    trit_dma_pkg::saddr_t       i_slave_address;
    trit_dma_pkg::sword_t       i_slave_writedata;
    logic [`TD_SDATA_W/8-1:0]   i_slave_byteenable;
    trit_dma_pkg::sword_t       o_slave_readdata;
    logic                       o_slave_waitrequest;
    logic                       o_slave_readdatavalid;
    trit_dma_pkg::maddr_t       o_master_address;
    logic                       o_master_read;
    logic                       o_master_write;
    trit_dma_pkg::mword_t       o_master_writedata;
    logic [`TD_MBE_W-1:0]       o_master_byteenable;
    logic                       i_master_waitrequest;
    trit_dma_pkg::mword_t       i_master_readdata;
    logic                       i_master_readdatavalid;
    logic                       o_finish_int;

    trit_dma_pkg::mword_t mem [MEM_WORDS];
    trit_dma_pkg::mword_t rd_word_q [$];
    int                   rd_due_q [$];
    logic [31:0]          rng_state = 32'hfd5f;
    logic [31:0]          bus_rnd;
    int                   cyc = 0;
    int                   due;
    int                   last_due = 0;
    int                   err_cnt = 0;
    int                   fin_rises = 0;
    logic                 fin_q = 1'b0;

    trit_dma_top dut_i (.*);

    bind trit_dma_top trit_dma_props props_i (
        .i_clk(i_clk), .i_arst(i_arst),
        .i_slave_read(i_slave_read), .i_slave_readdatavalid(o_slave_readdatavalid),
        .i_slave_waitrequest(o_slave_waitrequest),
        .i_master_read(o_master_read), .i_master_write(o_master_write),
        .i_master_address(o_master_address), .i_master_writedata(o_master_writedata),
        .i_master_waitrequest(i_master_waitrequest)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // distinct background value for each untouched word
    function automatic trit_dma_pkg::mword_t fill_word(input int a);
        return {4{32'hc0de_0000 ^ 32'(a)}};
    endfunction

    // sign-extended byte value of a trit slot
    function automatic logic [7:0] trit_byte(input trit_dma_pkg::trit_t t);
        case (t)
            2'b01:   return 8'h01;
            2'b11:   return 8'hff;
            default: return 8'h00;
        endcase
    endfunction

    function automatic trit_dma_pkg::sword_t merge_lanes(input trit_dma_pkg::sword_t old_v,
            input trit_dma_pkg::sword_t new_v, input logic [3:0] lanes);
        trit_dma_pkg::sword_t res;
        res = old_v;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    // random trits in the low bits with random junk above
    task automatic fill_source(input int base);
        trit_dma_pkg::mword_t w_v;
        logic [31:0]          r;
        trit_dma_pkg::trit_t  t;
        for (int w = 0; w < `TD_XFER_WORDS; w++) begin
            for (int b = 0; b < `TD_BYTES_PER_WORD; b++) begin
                r = next_rand();
                case (r[20:16] % 3)
                    0:       t = 2'b00;
                    1:       t = 2'b01;
                    default: t = 2'b11;
                endcase
                w_v[8*b +: 8] = {r[29:24], t};
            end
            mem[base + w] = w_v;
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
            input logic [127:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic host_write(input trit_dma_pkg::saddr_t a, input trit_dma_pkg::sword_t d,
            input logic [3:0] lanes);
        @(posedge i_clk);
        i_slave_write      <= 1'b1;
        i_slave_address    <= a;
        i_slave_writedata  <= d;
        i_slave_byteenable <= lanes;
        @(posedge i_clk);
        i_slave_write      <= 1'b0;
        i_slave_byteenable <= '0;
    endtask

    // readdata is valid in the read cycle and is taken at its closing edge
    task automatic host_read(input trit_dma_pkg::saddr_t a, output trit_dma_pkg::sword_t d);
        @(posedge i_clk);
        i_slave_read    <= 1'b1;
        i_slave_address <= a;
        @(posedge i_clk);
        d = o_slave_readdata;
        i_slave_read <= 1'b0;
    endtask

    task automatic run_transfer(input int run, input int src, input int dst);
        trit_dma_pkg::sword_t op;
        trit_dma_pkg::sword_t lo;
        trit_dma_pkg::sword_t hi;
        trit_dma_pkg::tick_t  ticks_a;
        trit_dma_pkg::tick_t  ticks_b;
        trit_dma_pkg::mword_t exp_w;
        int                   slot;
        host_write(`TD_REG_SRC, 32'(src), 4'hf);
        host_write(`TD_REG_DST, 32'(dst), 4'hf);
        host_write(`TD_REG_OP, 32'h2, 4'h1);
        // start must clear finish and raise busy
        host_read(`TD_REG_OP, op);
        check_value($sformatf("run%0d_op_busy", run), 32'h2, op);
        while (!o_finish_int) begin
            @(posedge i_clk);
        end
        host_read(`TD_REG_OP, op);
        check_value($sformatf("run%0d_op_finish", run), 32'h1, op);
        host_read(`TD_REG_TICK_LO, lo);
        host_read(`TD_REG_TICK_HI, hi);
        ticks_a = {hi, lo};
        repeat (8) @(posedge i_clk);
        host_read(`TD_REG_TICK_LO, lo);
        host_read(`TD_REG_TICK_HI, hi);
        ticks_b = {hi, lo};
        assert (ticks_a != '0) else begin
            $display("[FAIL] run%0d_ticks expected nonzero actual %h", run, ticks_a);
            err_cnt++;
        end
        check_value($sformatf("run%0d_ticks_hold", run), ticks_a, ticks_b);
        check_value($sformatf("run%0d_finish_rises", run), run, fin_rises);
        for (int w = 0; w < `TD_XFER_WORDS; w++) begin
            exp_w = '0;
            for (int b = 0; b < `TD_BYTES_PER_WORD; b++) begin
                slot = w * `TD_BYTES_PER_WORD + b;
                if (slot < `TD_NUM_TRITS) begin
                    exp_w[8*b +: 8] = trit_byte(
                        mem[src + slot / 16][8*(slot % 16) +: 2]);
                end
            end
            check_value($sformatf("run%0d_word%0d", run, w), exp_w, mem[dst + w]);
        end
        check_value($sformatf("run%0d_past_end", run), fill_word(dst + 6), mem[dst + 6]);
    endtask

    // memory model with random stalls and in-order reads after 1 to 4 cycles
    always @(posedge i_clk) begin
        if (o_master_read && !i_master_waitrequest) begin
            bus_rnd = next_rand();
            due = cyc + 1 + int'(bus_rnd[17:16]);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rd_due_q.push_back(due);
            rd_word_q.push_back(mem[o_master_address[5:0]]);
        end
        if (o_master_write && !i_master_waitrequest) begin
            // only enabled byte lanes are stored
            for (int b = 0; b < `TD_MBE_W; b++) begin
                if (o_master_byteenable[b]) begin
                    mem[o_master_address[5:0]][8*b +: 8] = o_master_writedata[8*b +: 8];
                end
            end
        end
        if (rd_due_q.size() != 0 && rd_due_q[0] == cyc) begin
            i_master_readdatavalid <= 1'b1;
            i_master_readdata      <= rd_word_q.pop_front();
            void'(rd_due_q.pop_front());
        end else begin
            i_master_readdatavalid <= 1'b0;
        end
        bus_rnd = next_rand();
        i_master_waitrequest <= (bus_rnd[19:18] == 2'b00);
        cyc++;
    end

    // interrupt edge counter
    always @(posedge i_clk) begin
        fin_q <= o_finish_int;
        if (o_finish_int && !fin_q) begin
            fin_rises <= fin_rises + 1;
        end
    end

    initial begin
        repeat (NUM_RUNS * RUN_CYCLES + 10) @(posedge i_clk);
        $display("watchdog expired before the transfers finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        trit_dma_pkg::sword_t rd;
        i_arst                 = 1'b1;
        i_slave_write          = 1'b0;
        i_slave_read           = 1'b0;
        i_slave_address        = '0;
        i_slave_writedata      = '0;
        i_slave_byteenable     = '0;
        i_master_waitrequest   = 1'b0;
        i_master_readdata      = '0;
        i_master_readdatavalid = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = fill_word(a);
        end
        fill_source(8);
        fill_source(40);
        fill_source(30);
        repeat (10) @(posedge i_clk);
        i_arst <= 1'b0;

        // partial lane writes
        host_write(`TD_REG_SRC, 32'h1122_3344, 4'hf);
        host_write(`TD_REG_SRC, 32'haabb_ccdd, 4'b1010);
        host_read(`TD_REG_SRC, rd);
        check_value("regs_src", merge_lanes(32'h1122_3344, 32'haabb_ccdd, 4'b1010), rd);
        host_write(`TD_REG_DST, 32'h5566_7788, 4'hf);
        host_write(`TD_REG_DST, 32'h0102_0304, 4'b0110);
        host_read(`TD_REG_DST, rd);
        check_value("regs_dst", merge_lanes(32'h5566_7788, 32'h0102_0304, 4'b0110), rd);
        host_read(3'd6, rd);
        check_value("regs_unmapped", 32'h0, rd);

        run_transfer(1, 8, 20);
        run_transfer(2, 40, 50);
        run_transfer(3, 30, 0);

        $display("checks failed: %0d, assertion failures: %0d",
                 err_cnt, dut_i.props_i.fail_cnt);
        if (err_cnt == 0 && dut_i.props_i.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/trit_dma_properties.sv
// bus protocol assertions for the trit transfer engine host and memory ports
`timescale 1ns/1ps
`default_nettype none

module trit_dma_props (
    input wire                  i_clk,
    input wire                  i_arst,
    input wire                  i_slave_read,
    input wire                  i_slave_readdatavalid,
    input wire                  i_slave_waitrequest,
    input wire                  i_master_read,
    input wire                  i_master_write,
    input trit_dma_pkg::maddr_t i_master_address,
    input trit_dma_pkg::mword_t i_master_writedata,
    input wire                  i_master_waitrequest
);

    int fail_cnt = 0;

    // host port answers every read in the same cycle
    a_host_valid: assert property (@(posedge i_clk) disable iff (i_arst)
        i_slave_readdatavalid == i_slave_read) else begin
        $error("host readdatavalid does not follow read");
        fail_cnt++;
    end

    a_host_nowait: assert property (@(posedge i_clk) disable iff (i_arst)
        !i_slave_waitrequest) else begin
        $error("host waitrequest went high");
        fail_cnt++;
    end

    // stalled read command holds
    a_rd_hold: assert property (@(posedge i_clk) disable iff (i_arst)
        (i_master_read && i_master_waitrequest) |=>
        (i_master_read && $stable(i_master_address))) else begin
        $error("read command changed while waitrequest was high");
        fail_cnt++;
    end

    a_wr_hold: assert property (@(posedge i_clk) disable iff (i_arst)
        (i_master_write && i_master_waitrequest) |=>
        (i_master_write && $stable(i_master_address) && $stable(i_master_writedata)))
        else begin
        $error("write command changed while waitrequest was high");
        fail_cnt++;
    end

    a_rw_excl: assert property (@(posedge i_clk) disable iff (i_arst)
        !(i_master_read && i_master_write)) else begin
        $error("master read and write high together");
        fail_cnt++;
    end

endmodule

`default_nettype wire

//--- verilog/host_regs.sv
// host register block with byte-lane writes, readback, start pulse and tick counter
`timescale 1ns/1ps
`default_nettype none
`include "trit_dma_consts.svh"

module host_regs (
    input  wire                        i_clk,
    input  wire                        i_arst,
    input  wire                        i_write,
    input  wire                        i_read,
    input  trit_dma_pkg::saddr_t       i_address,
    input  trit_dma_pkg::sword_t       i_writedata,
    input  wire [`TD_SDATA_W/8-1:0]    i_byteenable,
    input  wire                        i_busy,
    input  wire                        i_finish,
    output trit_dma_pkg::sword_t       o_readdata,
    output logic                       o_start,
    output trit_dma_pkg::maddr_t       o_src_addr,
    output trit_dma_pkg::maddr_t       o_dst_addr
);

    trit_dma_pkg::sword_t src_reg;
    trit_dma_pkg::sword_t dst_reg;
    trit_dma_pkg::tick_t  tick_cnt;

    // word addresses use the low bits only
    assign o_src_addr = src_reg[`TD_MADDR_W-1:0];
    assign o_dst_addr = dst_reg[`TD_MADDR_W-1:0];

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            src_reg <= '0;
            dst_reg <= '0;
            o_start <= 1'b0;
        end else begin
            o_start <= i_write && (i_address == `TD_REG_OP) &&
                       i_byteenable[0] && i_writedata[1];
            if (i_write) begin
                for (int i = 0; i < `TD_SDATA_W/8; i++) begin
                    if (i_byteenable[i]) begin
                        if (i_address == `TD_REG_SRC) begin
                            src_reg[8*i +: 8] <= i_writedata[8*i +: 8];
                        end
                        if (i_address == `TD_REG_DST) begin
                            dst_reg[8*i +: 8] <= i_writedata[8*i +: 8];
                        end
                    end
                end
            end
        end
    end

    // cycles spent busy since the last start
    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            tick_cnt <= '0;
        end else if (o_start) begin
            tick_cnt <= '0;
        end else if (i_busy) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // readback, zero when idle or unmapped
    always_comb begin
        o_readdata = '0;
        if (i_read) begin
            case (i_address)
                `TD_REG_OP:      o_readdata = {30'd0, i_busy, i_finish};
                `TD_REG_SRC:     o_readdata = src_reg;
                `TD_REG_DST:     o_readdata = dst_reg;
                `TD_REG_TICK_LO: o_readdata = tick_cnt[31:0];
                `TD_REG_TICK_HI: o_readdata = tick_cnt[63:32];
                default:         o_readdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/read_master.sv
// memory read master for the load phase with outstanding reads bounded by fifo room
`timescale 1ns/1ps
`default_nettype none
`include "trit_dma_consts.svh"

module read_master (
    input  wire                   i_clk,
    input  wire                   i_arst,
    input  wire                   i_go,
    input  trit_dma_pkg::maddr_t  i_base,
    input  wire                   i_waitrequest,
    input  wire                   i_readdatavalid,
    input  trit_dma_pkg::mword_t  i_readdata,
    input  wire                   i_pop,
    output trit_dma_pkg::maddr_t  o_address,
    output logic                  o_read,
    output trit_dma_pkg::mword_t  o_data,
    output logic                  o_avail
);

    localparam int DEPTH  = `TD_RD_FIFO_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int LEFT_W = $clog2(`TD_XFER_WORDS + 1);

    trit_dma_pkg::mword_t fifo_mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     fifo_cnt;
    logic [CNT_W-1:0]     pend_cnt;
    logic [CNT_W:0]       used;
    logic [LEFT_W-1:0]    cmd_left;
    trit_dma_pkg::maddr_t addr_q;
    logic                 accept;

    // in flight plus buffered, never more than the fifo holds
    assign used      = {1'b0, pend_cnt} + {1'b0, fifo_cnt};
    assign o_read    = (cmd_left != '0) && (used < (CNT_W+1)'(DEPTH));
    assign accept    = o_read && !i_waitrequest;
    assign o_address = addr_q;
    assign o_avail   = (fifo_cnt != '0);
    assign o_data    = fifo_mem[rd_ptr];

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            addr_q   <= '0;
            cmd_left <= '0;
            pend_cnt <= '0;
            fifo_cnt <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else begin
            if (i_go) begin
                addr_q   <= i_base;
                cmd_left <= LEFT_W'(`TD_XFER_WORDS);
            end else if (accept) begin
                addr_q   <= addr_q + 1'b1;
                cmd_left <= cmd_left - 1'b1;
            end
            case ({accept, i_readdatavalid})
                2'b10:   pend_cnt <= pend_cnt + 1'b1;
                2'b01:   pend_cnt <= pend_cnt - 1'b1;
                default: pend_cnt <= pend_cnt;
            endcase
            case ({i_readdatavalid, i_pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            if (i_readdatavalid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_readdatavalid) begin
            fifo_mem[wr_ptr] <= i_readdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/trit_dma_consts.svh
// trit transfer engine constants for bus widths, host register map and transfer sizes
`ifndef TRIT_DMA_CONSTS_SVH
`define TRIT_DMA_CONSTS_SVH

// memory master bus
`define TD_MDATA_W 128
`define TD_MBE_W 16
`define TD_MADDR_W 28

// host register port
`define TD_SDATA_W 32
`define TD_SADDR_W 3

// host register map
`define TD_REG_OP 3'd0
`define TD_REG_SRC 3'd1
`define TD_REG_DST 3'd2
`define TD_REG_TICK_LO 3'd3
`define TD_REG_TICK_HI 3'd4

// transfer shape
`define TD_XFER_WORDS 6
`define TD_NUM_TRITS 81
`define TD_ROW_TRITS 27
`define TD_BYTES_PER_WORD 16

// fifo depths, powers of two
`define TD_RD_FIFO_DEPTH 4
`define TD_WR_FIFO_DEPTH 4

`endif

//--- verilog/trit_dma_pkg.sv
// shared vector types and sequencer state encoding of the trit transfer engine
`default_nettype none
`include "trit_dma_consts.svh"

package trit_dma_pkg;

    // bus words and addresses
    typedef logic [`TD_MDATA_W-1:0] mword_t;
    typedef logic [`TD_MADDR_W-1:0] maddr_t;
    typedef logic [`TD_SDATA_W-1:0] sword_t;
    typedef logic [`TD_SADDR_W-1:0] saddr_t;

    // two's complement trit, 01 is +1, 11 is -1, 00 is 0
    typedef logic [1:0] trit_t;
    typedef logic [2*`TD_ROW_TRITS-1:0] trit_row_t;

    typedef logic [63:0] tick_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        STORE,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

//--- verilog/trit_dma_top.sv
// trit transfer engine top, host register port plus a 128-bit memory master
`timescale 1ns/1ps
`default_nettype none
`include "trit_dma_consts.svh"

module trit_dma_top (
    input  wire                       i_clk,
    input  wire                       i_arst,
    output logic                      o_finish_int,
    // host port
    input  wire                       i_slave_write,
    input  wire                       i_slave_read,
    input  trit_dma_pkg::saddr_t      i_slave_address,
    input  trit_dma_pkg::sword_t      i_slave_writedata,
    input  wire [`TD_SDATA_W/8-1:0]   i_slave_byteenable,
    output trit_dma_pkg::sword_t      o_slave_readdata,
    output logic                      o_slave_waitrequest,
    output logic                      o_slave_readdatavalid,
    // memory port
    output trit_dma_pkg::maddr_t      o_master_address,
    output logic                      o_master_read,
    output logic                      o_master_write,
    output trit_dma_pkg::mword_t      o_master_writedata,
    output logic [`TD_MBE_W-1:0]      o_master_byteenable,
    input  wire                       i_master_waitrequest,
    input  trit_dma_pkg::mword_t      i_master_readdata,
    input  wire                       i_master_readdatavalid
);

    trit_dma_pkg::maddr_t src_addr;
    trit_dma_pkg::maddr_t dst_addr;
    trit_dma_pkg::maddr_t rd_address;
    trit_dma_pkg::maddr_t wr_address;
    trit_dma_pkg::mword_t rd_data;
    trit_dma_pkg::mword_t wr_data;
    logic start;
    logic busy;
    logic finish;
    logic loading;
    logic rd_go;
    logic rd_pop;
    logic rd_avail;
    logic wr_go;
    logic wr_push;
    logic wr_full;
    logic wr_done;

    // host port never stalls, reads answer in the same cycle
    assign o_slave_waitrequest   = 1'b0;
    assign o_slave_readdatavalid = i_slave_read;

    assign o_master_address    = loading ? rd_address : wr_address;
    assign o_master_byteenable = {`TD_MBE_W{1'b1}};
    assign o_finish_int        = finish;

    host_regs regs_i (
        .i_clk(i_clk), .i_arst(i_arst),
        .i_write(i_slave_write), .i_read(i_slave_read),
        .i_address(i_slave_address), .i_writedata(i_slave_writedata),
        .i_byteenable(i_slave_byteenable),
        .i_busy(busy), .i_finish(finish),
        .o_readdata(o_slave_readdata), .o_start(start),
        .o_src_addr(src_addr), .o_dst_addr(dst_addr)
    );

    read_master rd_i (
        .i_clk(i_clk), .i_arst(i_arst), .i_go(rd_go), .i_base(src_addr),
        .i_waitrequest(i_master_waitrequest), .i_readdatavalid(i_master_readdatavalid),
        .i_readdata(i_master_readdata), .i_pop(rd_pop),
        .o_address(rd_address), .o_read(o_master_read),
        .o_data(rd_data), .o_avail(rd_avail)
    );

    write_master wr_i (
        .i_clk(i_clk), .i_arst(i_arst), .i_go(wr_go), .i_base(dst_addr),
        .i_push(wr_push), .i_wdata(wr_data), .i_waitrequest(i_master_waitrequest),
        .o_address(wr_address), .o_write(o_master_write),
        .o_writedata(o_master_writedata), .o_full(wr_full), .o_done(wr_done)
    );

    trit_sequencer seq_i (
        .i_clk(i_clk), .i_arst(i_arst), .i_start(start),
        .i_rd_data(rd_data), .i_rd_avail(rd_avail),
        .i_wr_full(wr_full), .i_wr_done(wr_done),
        .o_rd_go(rd_go), .o_rd_pop(rd_pop), .o_wr_go(wr_go),
        .o_wr_push(wr_push), .o_wr_data(wr_data),
        .o_busy(busy), .o_finish(finish), .o_loading(loading)
    );

endmodule

`default_nettype wire

//--- verilog/trit_sequencer.sv
// transfer sequencer, unpacks trits into the row buffer and packs them back as bytes
`timescale 1ns/1ps
`default_nettype none
`include "trit_dma_consts.svh"

module trit_sequencer (
    input  wire                   i_clk,
    input  wire                   i_arst,
    input  wire                   i_start,
    input  trit_dma_pkg::mword_t  i_rd_data,
    input  wire                   i_rd_avail,
    input  wire                   i_wr_full,
    input  wire                   i_wr_done,
    output logic                  o_rd_go,
    output logic                  o_rd_pop,
    output logic                  o_wr_go,
    output logic                  o_wr_push,
    output trit_dma_pkg::mword_t  o_wr_data,
    output logic                  o_busy,
    output logic                  o_finish,
    output logic                  o_loading
);

    localparam int ROWS   = `TD_NUM_TRITS / `TD_ROW_TRITS;
    localparam int SLOTS  = `TD_XFER_WORDS * `TD_BYTES_PER_WORD;
    localparam int BYTE_W = $clog2(`TD_BYTES_PER_WORD);
    localparam int SLOT_W = $clog2(SLOTS + 1);
    localparam int COL_W  = $clog2(`TD_ROW_TRITS);
    localparam int ROW_W  = $clog2(ROWS);

    trit_dma_pkg::seq_state_t state;
    trit_dma_pkg::trit_row_t  rows [ROWS];
    trit_dma_pkg::trit_t      cur_trit;
    logic [BYTE_W-1:0]        byte_cnt;
    logic [SLOT_W-1:0]        slot_cnt;
    logic [COL_W-1:0]         col_cnt;
    logic [ROW_W-1:0]         row_idx;
    logic                     load_take;
    logic                     store_take;
    logic                     last_byte;
    logic                     last_trit;

    assign last_byte  = (byte_cnt == BYTE_W'(`TD_BYTES_PER_WORD - 1));
    assign last_trit  = (slot_cnt == SLOT_W'(`TD_NUM_TRITS - 1));
    assign load_take  = (state == trit_dma_pkg::LOAD) && i_rd_avail;
    assign store_take = (state == trit_dma_pkg::STORE) && !i_wr_full &&
                        (slot_cnt != SLOT_W'(SLOTS));
    assign cur_trit   = rows[row_idx][2*col_cnt +: 2];

    // start is only honoured between transfers
    assign o_rd_go   = i_start && (state == trit_dma_pkg::IDLE || state == trit_dma_pkg::DONE);
    assign o_rd_pop  = load_take && (last_byte || last_trit);
    assign o_wr_go   = load_take && last_trit;
    assign o_busy    = (state == trit_dma_pkg::LOAD) || (state == trit_dma_pkg::STORE);
    assign o_finish  = (state == trit_dma_pkg::DONE);
    assign o_loading = (state == trit_dma_pkg::LOAD);

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            state     <= trit_dma_pkg::IDLE;
            byte_cnt  <= '0;
            slot_cnt  <= '0;
            col_cnt   <= '0;
            row_idx   <= '0;
            o_wr_push <= 1'b0;
        end else begin
            // push lands one cycle after the 16th byte is written
            o_wr_push <= store_take && last_byte;
            if (o_rd_go || o_wr_go) begin
                state    <= o_rd_go ? trit_dma_pkg::LOAD : trit_dma_pkg::STORE;
                byte_cnt <= '0;
                slot_cnt <= '0;
                col_cnt  <= '0;
                row_idx  <= '0;
            end else if (load_take || store_take) begin
                byte_cnt <= byte_cnt + 1'b1;
                slot_cnt <= slot_cnt + 1'b1;
                if (col_cnt == COL_W'(`TD_ROW_TRITS - 1)) begin
                    col_cnt <= '0;
                    // wrap keeps the row index inside the buffer past trit 80
                    row_idx <= (row_idx == ROW_W'(ROWS - 1)) ? '0 : row_idx + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end else if (state == trit_dma_pkg::STORE && i_wr_done) begin
                state <= trit_dma_pkg::DONE;
            end
        end
    end

    // trit buffer and outgoing word
    always_ff @(posedge i_clk) begin
        if (load_take) begin
            rows[row_idx][2*col_cnt +: 2] <= i_rd_data[8*byte_cnt +: 2];
        end
        if (store_take) begin
            if (slot_cnt < SLOT_W'(`TD_NUM_TRITS)) begin
                o_wr_data[8*byte_cnt +: 8] <= {{6{cur_trit[1]}}, cur_trit};
            end else begin
                o_wr_data[8*byte_cnt +: 8] <= 8'h00;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/write_master.sv
// memory write master for the store phase, drains a small fifo to consecutive addresses
`timescale 1ns/1ps
`default_nettype none
`include "trit_dma_consts.svh"

module write_master (
    input  wire                   i_clk,
    input  wire                   i_arst,
    input  wire                   i_go,
    input  trit_dma_pkg::maddr_t  i_base,
    input  wire                   i_push,
    input  trit_dma_pkg::mword_t  i_wdata,
    input  wire                   i_waitrequest,
    output trit_dma_pkg::maddr_t  o_address,
    output logic                  o_write,
    output trit_dma_pkg::mword_t  o_writedata,
    output logic                  o_full,
    output logic                  o_done
);

    localparam int DEPTH  = `TD_WR_FIFO_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int DONE_W = $clog2(`TD_XFER_WORDS + 1);

    trit_dma_pkg::mword_t fifo_mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     fifo_cnt;
    logic [DONE_W-1:0]    wr_cnt;
    trit_dma_pkg::maddr_t addr_q;
    logic                 accept;

    // command stays up with head data until the bus takes it
    assign o_write     = (fifo_cnt != '0);
    assign accept      = o_write && !i_waitrequest;
    assign o_writedata = fifo_mem[rd_ptr];
    assign o_address   = addr_q;
    assign o_full      = (fifo_cnt == CNT_W'(DEPTH));
    assign o_done      = (wr_cnt == DONE_W'(`TD_XFER_WORDS));

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            addr_q   <= '0;
            wr_cnt   <= '0;
            fifo_cnt <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else begin
            if (i_go) begin
                addr_q <= i_base;
                wr_cnt <= '0;
            end else if (accept) begin
                addr_q <= addr_q + 1'b1;
                wr_cnt <= wr_cnt + 1'b1;
            end
            case ({i_push, accept})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            fifo_mem[wr_ptr] <= i_wdata;
        end
    end

endmodule

`default_nettype wire
